/* project.f */
+incdir+include
source/jump_pkg.sv
source/core_if.sv
source/fetch_unit.sv
source/jump_unit.sv
source/reg_file.sv
source/exec_stage.sv
source/ctrl_regs.sv
source/jump_core_top.sv
tests/tb_jump_core.sv

/* run_sim.sh */
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_jump_core -f project.f -o sim_jump_core

./obj_dir/sim_jump_core | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation log is clean"

/* include/tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Program lengths in words, the watchdog is sized from these
localparam int LEN_ALU  = 7;
localparam int LEN_JIDX = 8;
localparam int LEN_JREG = 16;

// Word-addressed instruction memory, read combinationally by the DUT
logic [31:0] imem [1 << IMEM_AW];

////////////////////////////////////////////////////////////
// Instruction encoders
////////////////////////////////////////////////////////////

function automatic logic [31:0] addiu_word(input logic [4:0] rt, input logic [4:0] rs,
                                           input logic [15:0] imm);
    return {6'b001001, rs, rt, imm};
endfunction

function automatic logic [31:0] addu_word(input logic [4:0] rd, input logic [4:0] rs,
                                          input logic [4:0] rt);
    return {6'b000000, rs, rt, rd, 5'd0, 6'b100001};
endfunction

function automatic logic [31:0] j_word(input logic [25:0] index);
    return {6'b000010, index};
endfunction

function automatic logic [31:0] jal_word(input logic [25:0] index);
    return {6'b000011, index};
endfunction

function automatic logic [31:0] jr_word(input logic [4:0] rs);
    return {6'b000000, rs, 15'd0, 6'b001000};
endfunction

function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs);
    return {6'b000000, rs, 5'd0, rd, 5'd0, 6'b001001};
endfunction

////////////////////////////////////////////////////////////
// Memory fill and program placement
////////////////////////////////////////////////////////////

task automatic load_program(input int id, input logic [31:0] base, output int len);
    logic [31:0]        prog [$];
    logic [IMEM_AW-1:0] first;
    // Unused opcode 0x3f decodes as a no-op, low bits carry the address
    for (int a = 0; a < (1 << IMEM_AW); a++) begin
        imem[a] = {6'h3f, 6'h15, 10'(a), ~10'(a)};
    end
    case (id)
        0: begin
            prog.push_back(addiu_word(5'd1, 5'd0, 16'd5));
            prog.push_back(addiu_word(5'd2, 5'd1, 16'hfffd));
            prog.push_back(addu_word(5'd3, 5'd1, 5'd2));
            // Write to r0 must be dropped
            prog.push_back(addiu_word(5'd0, 5'd0, 16'd9));
            prog.push_back(addu_word(5'd4, 5'd0, 5'd3));
            prog.push_back(addiu_word(5'd5, 5'd4, 16'h7fff));
            prog.push_back(addu_word(5'd6, 5'd5, 5'd5));
        end
        1: begin
            prog.push_back(addiu_word(5'd1, 5'd0, 16'd1));
            prog.push_back(j_word(26'd2));
            prog.push_back(addiu_word(5'd9, 5'd9, 16'd1));
            prog.push_back(jal_word(26'd2));
            prog.push_back(addiu_word(5'd9, 5'd9, 16'd1));
            prog.push_back(addu_word(5'd2, 5'd31, 5'd1));
            prog.push_back(j_word(26'd1));
            prog.push_back(addiu_word(5'd3, 5'd0, 16'd3));
        end
        default: begin
            prog.push_back(addiu_word(5'd1, 5'd0, 16'(base + 32'h14)));
            prog.push_back(jr_word(5'd1));
            prog.push_back(addiu_word(5'd9, 5'd9, 16'd1));
            prog.push_back(addiu_word(5'd9, 5'd9, 16'd1));
            prog.push_back(addiu_word(5'd9, 5'd9, 16'd1));
            prog.push_back(addiu_word(5'd2, 5'd0, 16'(base + 32'h20)));
            prog.push_back(jalr_word(5'd7, 5'd2));
            prog.push_back(j_word(26'd3));
            // Return through the link written just before
            prog.push_back(jr_word(5'd7));
            prog.push_back(addiu_word(5'd9, 5'd9, 16'd1));
            prog.push_back(jal_word(26'd2));
            prog.push_back(j_word(26'd2));
            prog.push_back(jr_word(5'd31));
            prog.push_back(addiu_word(5'd4, 5'd0, 16'(base + 32'h3c)));
            prog.push_back(jalr_word(5'd0, 5'd4));
            prog.push_back(addiu_word(5'd5, 5'd31, 16'd4));
        end
    endcase
    first = base[IMEM_AW+1:2];
    for (int i = 0; i < prog.size(); i++) begin
        imem[(int'(first) + i) % (1 << IMEM_AW)] = prog[i];
    end
    len = prog.size();
endtask

`endif

/* tests/tb_jump_core.sv */
`timescale 1ns/1ps

module tb_jump_core;

    localparam int IMEM_AW    = 10;
    localparam int CNT_W      = 16;
    localparam int CLK_PERIOD = 10;

    `include "tb_programs.svh"

    // Forty cycles per program word plus room for reset and config
    localparam int WATCHDOG_CYCLES = (LEN_ALU + LEN_JIDX + 2 * LEN_JREG) * 40 + 4 * 80;

    logic               clk = 1'b0;
    logic               i_rst = 1'b1;
    logic [IMEM_AW-1:0] o_imem_addr;
    logic [31:0]        i_imem_data;
    logic               i_cfg_we = 1'b0;
    logic [1:0]         i_cfg_addr = 2'd0;
    logic [31:0]        i_cfg_wdata = '0;
    logic [31:0]        o_cfg_rdata;
    logic               o_ret_valid;
    logic               i_ret_ready = 1'b0;
    logic [31:0]        o_ret_pc;
    logic               o_ret_we;
    logic [4:0]         o_ret_waddr;
    logic [31:0]        o_ret_wdata;
    logic               o_ret_jump;

    int          seed = 20972;
    logic        checking = 1'b0;
    int unsigned ready_pct = 100;
    logic [31:0] boot_pc = '0;
    logic [31:0] model_pc;
    logic [31:0] model_regs [32];
    int          retired;
    int          jumps_seen;
    int          checks = 0;
    int          errors = 0;

    // Snapshot of a record left waiting by back-pressure
    logic        held;
    logic [31:0] held_pc;
    logic        held_we;
    logic [4:0]  held_waddr;
    logic [31:0] held_wdata;
    logic        held_jump;

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign i_imem_data = imem[o_imem_addr];

    jump_core_top #(
        .IMEM_AW (IMEM_AW),
        .CNT_W   (CNT_W)
    ) uut (
        .i_clk       (clk),
        .i_rst       (i_rst),
        .o_imem_addr (o_imem_addr),
        .i_imem_data (i_imem_data),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_addr  (i_cfg_addr),
        .i_cfg_wdata (i_cfg_wdata),
        .o_cfg_rdata (o_cfg_rdata),
        .o_ret_valid (o_ret_valid),
        .i_ret_ready (i_ret_ready),
        .o_ret_pc    (o_ret_pc),
        .o_ret_we    (o_ret_we),
        .o_ret_waddr (o_ret_waddr),
        .o_ret_wdata (o_ret_wdata),
        .o_ret_jump  (o_ret_jump)
    );

    task automatic compare_field(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        assert (actual === expected)
        else begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    task automatic write_cfg(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk);
        i_cfg_we    = 1'b1;
        i_cfg_addr  = addr;
        i_cfg_wdata = data;
        @(negedge clk);
        i_cfg_we = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model stepped once per retire handshake
    ////////////////////////////////////////////////////////////

    task automatic check_retire();
        logic [31:0] w;
        logic [31:0] exp_target;
        logic [31:0] exp_wdata;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  exp_waddr;
        logic        exp_we;
        logic        exp_jump;
        compare_field("o_ret_pc", model_pc, o_ret_pc);
        w          = imem[model_pc[IMEM_AW+1:2]];
        rs         = w[25:21];
        rt         = w[20:16];
        rd         = w[15:11];
        exp_we     = 1'b0;
        exp_jump   = 1'b0;
        exp_waddr  = 5'd0;
        exp_wdata  = '0;
        exp_target = model_pc + {4'b0, w[25:0], 2'b00};
        case (w[31:26])
            6'b000010: exp_jump = 1'b1;
            6'b000011: begin
                exp_jump  = 1'b1;
                exp_we    = 1'b1;
                exp_waddr = 5'd31;
                exp_wdata = model_pc + 32'd4;
            end
            6'b001001: begin
                exp_we    = 1'b1;
                exp_waddr = rt;
                exp_wdata = model_regs[rs] + {{16{w[15]}}, w[15:0]};
            end
            6'b000000: begin
                if (w[5:0] == 6'b001000) begin
                    exp_jump   = 1'b1;
                    exp_target = model_regs[rs];
                end else if (w[5:0] == 6'b001001) begin
                    exp_jump   = 1'b1;
                    exp_target = model_regs[rs];
                    exp_we     = 1'b1;
                    exp_waddr  = rd;
                    exp_wdata  = model_pc + 32'd4;
                end else if (w[5:0] == 6'b100001) begin
                    exp_we    = 1'b1;
                    exp_waddr = rd;
                    exp_wdata = model_regs[rs] + model_regs[rt];
                end
            end
            default: exp_we = 1'b0;
        endcase
        // r0 stays zero
        if (exp_waddr == 5'd0) begin
            exp_we = 1'b0;
        end
        compare_field("o_ret_we", 32'(exp_we), 32'(o_ret_we));
        compare_field("o_ret_jump", 32'(exp_jump), 32'(o_ret_jump));
        if (exp_we) begin
            compare_field("o_ret_waddr", 32'(exp_waddr), 32'(o_ret_waddr));
            compare_field("o_ret_wdata", exp_wdata, o_ret_wdata);
            model_regs[exp_waddr] = exp_wdata;
        end
        model_pc = exp_jump ? exp_target : model_pc + 32'd4;
        retired++;
        if (exp_jump) begin
            jumps_seen++;
        end
    endtask

    // Ready drive and retire sampling on the falling edge
    always @(negedge clk) begin
        int unsigned roll;
        logic        rdy;
        if (!checking) begin
            i_ret_ready = 1'b0;
            held        = 1'b0;
            model_pc    = boot_pc;
            retired     = 0;
            jumps_seen  = 0;
            for (int r = 0; r < 32; r++) begin
                model_regs[r] = '0;
            end
        end else begin
            if (held) begin
                compare_field("o_ret_valid", 32'd1, 32'(o_ret_valid));
                compare_field("o_ret_pc", held_pc, o_ret_pc);
                compare_field("o_ret_we", 32'(held_we), 32'(o_ret_we));
                compare_field("o_ret_waddr", 32'(held_waddr), 32'(o_ret_waddr));
                compare_field("o_ret_wdata", held_wdata, o_ret_wdata);
                compare_field("o_ret_jump", 32'(held_jump), 32'(o_ret_jump));
            end
            roll        = $unsigned($random(seed)) % 32'd100;
            rdy         = (roll < ready_pct);
            i_ret_ready = rdy;
            if (o_ret_valid && rdy) begin
                check_retire();
            end
            held       = o_ret_valid && !rdy;
            held_pc    = o_ret_pc;
            held_we    = o_ret_we;
            held_waddr = o_ret_waddr;
            held_wdata = o_ret_wdata;
            held_jump  = o_ret_jump;
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    task automatic run_test(input int id, input string name, input logic [31:0] base,
                            input int unsigned pct);
        int          len;
        int          idle;
        int          errors_before;
        logic [31:0] end_pc;
        @(negedge clk);
        i_rst    = 1'b1;
        checking = 1'b0;
        load_program(id, base, len);
        boot_pc       = base;
        ready_pct     = pct;
        end_pc        = base + 32'(len * 4);
        errors_before = errors;
        repeat (10) @(negedge clk);
        i_rst = 1'b0;
        @(posedge clk);
        checking = 1'b1;
        write_cfg(2'd1, base);
        compare_field("o_cfg_rdata", base, o_cfg_rdata);
        write_cfg(2'd0, 32'd1);
        compare_field("o_cfg_rdata", 32'd1, o_cfg_rdata);
        while (model_pc != end_pc) begin
            @(posedge clk);
        end
        // Stop fetch, then let the buffer and retire slot drain
        write_cfg(2'd0, 32'd0);
        idle = 0;
        while (idle < 3) begin
            @(negedge clk);
            if (o_ret_valid) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
        i_cfg_addr = 2'd2;
        @(negedge clk);
        compare_field("o_cfg_rdata", 32'(jumps_seen), o_cfg_rdata);
        $display("Test %s: %0d retired, %0d jumps, %0d errors",
                 name, retired, jumps_seen, errors - errors_before);
        @(posedge clk);
        checking = 1'b0;
    endtask

    initial begin
        run_test(0, "alu", 32'h0000_0100, 100);
        run_test(1, "jump_index", 32'h0000_0040, 50);
        run_test(2, "jump_reg", 32'h0000_0200, 100);
        run_test(2, "jump_reg_backpressure", 32'h0000_0300, 35);
        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the programs did not finish retiring in time");
        $display("Something failed");
        $finish;
    end

endmodule

/* source/jump_core_top.sv */
`timescale 1ns/1ps

module jump_core_top import jump_pkg::*; #(
    parameter int IMEM_AW = 10,
    parameter int CNT_W   = 16
) (
    input  logic               i_clk,
    input  logic               i_rst,
    output logic [IMEM_AW-1:0] o_imem_addr,
    input  word_t              i_imem_data,
    input  logic               i_cfg_we,
    input  logic [1:0]         i_cfg_addr,
    input  word_t              i_cfg_wdata,
    output word_t              o_cfg_rdata,
    output logic               o_ret_valid,
    input  logic               i_ret_ready,
    output word_t              o_ret_pc,
    output logic               o_ret_we,
    output reg_idx_t           o_ret_waddr,
    output word_t              o_ret_wdata,
    output logic               o_ret_jump
);

    fetch_if f_bus ();
    rf_if    rf_bus ();

    logic  run;
    logic  start;
    logic  jump_taken;
    word_t boot_addr;

    // Execute to jump unit
    word_t jmp_pc;
    word_t jmp_instr;
    word_t jmp_reg_a;
    word_t jmp_target;
    word_t jmp_link;
    logic  jmp_take;
    logic  jmp_do_link;
    logic  jmp_rd_sel;

    ////////////////////////////////////////////////////////////
    // Front end
    ////////////////////////////////////////////////////////////

    ctrl_regs #(.CNT_W(CNT_W)) u_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_cfg_we     (i_cfg_we),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_wdata  (i_cfg_wdata),
        .o_cfg_rdata  (o_cfg_rdata),
        .i_jump_taken (jump_taken),
        .o_run        (run),
        .o_start      (start),
        .o_boot_addr  (boot_addr)
    );

    fetch_unit #(.IMEM_AW(IMEM_AW)) u_fetch (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_run       (run),
        .i_start     (start),
        .i_boot_addr (boot_addr),
        .o_imem_addr (o_imem_addr),
        .i_imem_data (i_imem_data),
        .f           (f_bus.src)
    );

    ////////////////////////////////////////////////////////////
    // Execute, jump decision and registers
    ////////////////////////////////////////////////////////////

    exec_stage u_exec (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .f             (f_bus.dst),
        .rf            (rf_bus.ctl),
        .o_jmp_pc      (jmp_pc),
        .o_jmp_instr   (jmp_instr),
        .o_jmp_reg_a   (jmp_reg_a),
        .i_jmp_target  (jmp_target),
        .i_jmp_link    (jmp_link),
        .i_jmp_take    (jmp_take),
        .i_jmp_do_link (jmp_do_link),
        .i_jmp_rd_sel  (jmp_rd_sel),
        .o_ret_valid   (o_ret_valid),
        .i_ret_ready   (i_ret_ready),
        .o_ret_pc      (o_ret_pc),
        .o_ret_we      (o_ret_we),
        .o_ret_waddr   (o_ret_waddr),
        .o_ret_wdata   (o_ret_wdata),
        .o_ret_jump    (o_ret_jump),
        .o_jump_taken  (jump_taken)
    );

    jump_unit u_jump (
        .i_pc      (jmp_pc),
        .i_instr   (jmp_instr),
        .i_reg_a   (jmp_reg_a),
        .o_target  (jmp_target),
        .o_link    (jmp_link),
        .o_take    (jmp_take),
        .o_do_link (jmp_do_link),
        .o_rd_sel  (jmp_rd_sel)
    );

    reg_file u_rf (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .rf    (rf_bus.mem)
    );

endmodule

/* source/ctrl_regs.sv */
`timescale 1ns/1ps

module ctrl_regs import jump_pkg::*; #(
    parameter int CNT_W = 16
) (
    input  logic       i_clk,
    input  logic       i_rst,
    input  logic       i_cfg_we,
    input  logic [1:0] i_cfg_addr,
    input  word_t      i_cfg_wdata,
    output word_t      o_cfg_rdata,
    input  logic       i_jump_taken,
    output logic       o_run,
    output logic       o_start,
    output word_t      o_boot_addr
);

    localparam logic [1:0] ADDR_RUN  = 2'd0;
    localparam logic [1:0] ADDR_BOOT = 2'd1;
    localparam logic [1:0] ADDR_CNT  = 2'd2;

    logic             run_q;
    logic             run_prev;
    word_t            boot_q;
    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            run_q    <= 1'b0;
            run_prev <= 1'b0;
            boot_q   <= '0;
        end else begin
            run_prev <= run_q;
            if (i_cfg_we && (i_cfg_addr == ADDR_RUN)) begin
                run_q <= i_cfg_wdata[0];
            end
            if (i_cfg_we && (i_cfg_addr == ADDR_BOOT)) begin
                boot_q <= i_cfg_wdata;
            end
        end
    end

    // Taken-jump count, sticks at all ones
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cnt_q <= '0;
        end else if (i_jump_taken && (cnt_q != {CNT_W{1'b1}})) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_comb begin
        case (i_cfg_addr)
            ADDR_RUN:  o_cfg_rdata = {31'b0, run_q};
            ADDR_BOOT: o_cfg_rdata = boot_q;
            ADDR_CNT:  o_cfg_rdata = word_t'(cnt_q);
            default:   o_cfg_rdata = '0;
        endcase
    end

    // One-cycle pulse on the rising edge of run
    assign o_start     = run_q && !run_prev;
    assign o_run       = run_q;
    assign o_boot_addr = boot_q;

endmodule

/* source/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage import jump_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst,
    fetch_if.dst     f,
    rf_if.ctl        rf,
    output word_t    o_jmp_pc,
    output word_t    o_jmp_instr,
    output word_t    o_jmp_reg_a,
    input  word_t    i_jmp_target,
    input  word_t    i_jmp_link,
    input  logic     i_jmp_take,
    input  logic     i_jmp_do_link,
    input  logic     i_jmp_rd_sel,
    output logic     o_ret_valid,
    input  logic     i_ret_ready,
    output word_t    o_ret_pc,
    output logic     o_ret_we,
    output reg_idx_t o_ret_waddr,
    output word_t    o_ret_wdata,
    output logic     o_ret_jump,
    output logic     o_jump_taken
);

    exec_state_t state_q;
    exec_state_t state_d;
    logic        redirect_q;
    word_t       redirect_pc_q;
    logic        accept;
    opcode_t     op;
    funct_t      fn;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    word_t       imm_sext;
    logic        is_addu;
    logic        is_addiu;
    logic        wr_en;
    logic        wr_ok;
    reg_idx_t    waddr_c;
    word_t       wdata_c;

    assign op = f.instr[31:26];
    assign fn = f.instr[5:0];
    assign rs = f.instr[25:21];
    assign rt = f.instr[20:16];
    assign rd = f.instr[15:11];
    assign imm_sext = {{16{f.instr[15]}}, f.instr[15:0]};

    assign is_addu  = (op == OP_SPECIAL) && (fn == FN_ADDU);
    assign is_addiu = (op == OP_ADDIU);

    // No new word while a flush is pending or the retire slot is stuck
    assign f.ready = !redirect_q && ((state_q == EX_IDLE) || i_ret_ready);
    assign accept  = f.valid && f.ready;

    assign o_jmp_pc    = f.pc;
    assign o_jmp_instr = f.instr;
    assign o_jmp_reg_a = rf.rdata_a;

    ////////////////////////////////////////////////////////////
    // Writeback selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        wr_en   = 1'b0;
        waddr_c = '0;
        wdata_c = '0;
        if (i_jmp_do_link) begin
            wr_en   = 1'b1;
            waddr_c = i_jmp_rd_sel ? LINK_REG : rd;
            wdata_c = i_jmp_link;
        end else if (is_addu) begin
            wr_en   = 1'b1;
            waddr_c = rd;
            wdata_c = rf.rdata_a + rf.rdata_b;
        end else if (is_addiu) begin
            wr_en   = 1'b1;
            waddr_c = rt;
            wdata_c = rf.rdata_a + imm_sext;
        end
    end

    // Writes to r0 are dropped
    assign wr_ok = wr_en && (waddr_c != '0);

    assign rf.ra    = rs;
    assign rf.rb    = rt;
    assign rf.we    = accept && wr_ok;
    assign rf.waddr = waddr_c;
    assign rf.wdata = wdata_c;

    assign f.redirect    = redirect_q;
    assign f.redirect_pc = redirect_pc_q;
    assign o_jump_taken  = accept && i_jmp_take;

    ////////////////////////////////////////////////////////////
    // Retire slot
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            EX_IDLE: begin
                if (accept) begin
                    state_d = EX_BUSY;
                end
            end
            EX_BUSY, EX_HOLD: begin
                if (accept) begin
                    state_d = EX_BUSY;
                end else if (i_ret_ready) begin
                    state_d = EX_IDLE;
                end else begin
                    state_d = EX_HOLD;
                end
            end
            default: state_d = EX_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q    <= EX_IDLE;
            redirect_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            redirect_q <= accept && i_jmp_take;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            redirect_pc_q <= i_jmp_target;
            o_ret_pc      <= f.pc;
            o_ret_we      <= wr_ok;
            o_ret_waddr   <= wr_ok ? waddr_c : '0;
            o_ret_wdata   <= wr_ok ? wdata_c : '0;
            o_ret_jump    <= i_jmp_take;
        end
    end

    assign o_ret_valid = (state_q != EX_IDLE);

    // Held record must not change under back-pressure
    property p_ret_stable;
        @(posedge i_clk) disable iff (i_rst)
        o_ret_valid && !i_ret_ready |=> o_ret_valid && $stable(o_ret_pc)
            && $stable(o_ret_we) && $stable(o_ret_waddr)
            && $stable(o_ret_wdata) && $stable(o_ret_jump);
    endproperty
    a_ret_stable: assert property (p_ret_stable);

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file import jump_pkg::*; (
    input logic i_clk,
    input logic i_rst,
    rf_if.mem   rf
);

    word_t regs [32];

    ////////////////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf.we) begin
            regs[rf.waddr] <= rf.wdata;
        end
    end

    // Read ports, r0 is hardwired to zero
    assign rf.rdata_a = (rf.ra == '0) ? '0 : regs[rf.ra];
    assign rf.rdata_b = (rf.rb == '0) ? '0 : regs[rf.rb];

    // Execute filters r0 writes before they get here
    property p_no_r0_write;
        @(posedge i_clk) disable iff (i_rst)
        rf.we |-> (rf.waddr != '0);
    endproperty
    a_no_r0_write: assert property (p_no_r0_write);

endmodule

/* source/jump_unit.sv */
`timescale 1ns/1ps

module jump_unit import jump_pkg::*; (
    input  word_t i_pc,
    input  word_t i_instr,
    input  word_t i_reg_a,
    output word_t o_target,
    output word_t o_link,
    output logic  o_take,
    output logic  o_do_link,
    output logic  o_rd_sel
);

    opcode_t op;
    funct_t  fn;
    word_t   index_target;

    assign op = i_instr[31:26];
    assign fn = i_instr[5:0];

    // J and JAL are PC relative here, index scaled to bytes
    assign index_target = i_pc + word_t'({i_instr[25:0], 2'b00});

    // Byte addressed, next instruction is four bytes on
    assign o_link = i_pc + 32'd4;

    ////////////////////////////////////////////////////////////
    // Jump decision
    ////////////////////////////////////////////////////////////

    always_comb begin
        o_take    = 1'b0;
        o_do_link = 1'b0;
        o_rd_sel  = 1'b0;
        o_target  = index_target;
        case (op)
            OP_J: begin
                o_take = 1'b1;
            end
            OP_JAL: begin
                o_take    = 1'b1;
                o_do_link = 1'b1;
                // Link goes to r31, not rd
                o_rd_sel  = 1'b1;
            end
            OP_SPECIAL: begin
                if (fn == FN_JR) begin
                    o_target = i_reg_a;
                    o_take   = 1'b1;
                end else if (fn == FN_JALR) begin
                    o_target  = i_reg_a;
                    o_take    = 1'b1;
                    o_do_link = 1'b1;
                end
            end
            default: begin
                o_take = 1'b0;
            end
        endcase
    end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit import jump_pkg::*; #(
    parameter int IMEM_AW = 10
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_run,
    input  logic               i_start,
    input  word_t              i_boot_addr,
    output logic [IMEM_AW-1:0] o_imem_addr,
    input  word_t              i_imem_data,
    fetch_if.src               f
);

    word_t pc_q;
    word_t buf_pc;
    word_t buf_instr;
    logic  buf_valid;
    logic  take;
    logic  fetch_en;

    assign take = buf_valid && f.ready;

    // Buffer has room when empty or drained this cycle
    assign fetch_en = i_run && !i_start && !f.redirect && (!buf_valid || take);

    // Word address into instruction memory
    assign o_imem_addr = pc_q[IMEM_AW+1:2];

    assign f.pc    = buf_pc;
    assign f.instr = buf_instr;
    assign f.valid = buf_valid;

    ////////////////////////////////////////////////////////////
    // PC and buffer occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_q      <= '0;
            buf_valid <= 1'b0;
        end else if (f.redirect) begin
            // Wrong-path word in the buffer is dropped
            pc_q      <= f.redirect_pc;
            buf_valid <= 1'b0;
        end else if (i_start) begin
            pc_q      <= i_boot_addr;
            buf_valid <= 1'b0;
        end else if (fetch_en) begin
            pc_q      <= pc_q + 32'd4;
            buf_valid <= 1'b1;
        end else if (take) begin
            buf_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (fetch_en) begin
            buf_pc    <= pc_q;
            buf_instr <= i_imem_data;
        end
    end

    // Offered word is held until execute takes it, unless flushed
    property p_valid_hold;
        @(posedge i_clk) disable iff (i_rst)
        f.valid && !f.ready && !f.redirect && !i_start |=> f.valid && $stable(f.instr);
    endproperty
    a_valid_hold: assert property (p_valid_hold);

endmodule

/* source/core_if.sv */
`timescale 1ns/1ps

// Instruction handshake from fetch, redirect path back from execute
interface fetch_if import jump_pkg::*; ();
    word_t pc;
    word_t instr;
    logic  valid;
    logic  ready;
    logic  redirect;
    word_t redirect_pc;

    modport src (
        output pc, instr, valid,
        input  ready, redirect, redirect_pc
    );

    modport dst (
        input  pc, instr, valid,
        output ready, redirect, redirect_pc
    );
endinterface

// Two read ports and one write port of the register file
interface rf_if import jump_pkg::*; ();
    reg_idx_t ra;
    reg_idx_t rb;
    logic     we;
    reg_idx_t waddr;
    word_t    wdata;
    word_t    rdata_a;
    word_t    rdata_b;

    modport ctl (
        output ra, rb, we, waddr, wdata,
        input  rdata_a, rdata_b
    );

    modport mem (
        input  ra, rb, we, waddr, wdata,
        output rdata_a, rdata_b
    );
endinterface

/* source/jump_pkg.sv */
package jump_pkg;

    // Data, PC and instruction words share one width
    typedef logic [31:0] word_t;

    typedef logic [4:0] reg_idx_t;

    typedef logic [5:0] opcode_t;

    typedef logic [5:0] funct_t;

    ////////////////////////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////////////////////////

    // R-type group, decoded further by the function field
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_ADDIU   = 6'b001001;

    ////////////////////////////////////////////////////////////
    // Function field of the R-type group
    ////////////////////////////////////////////////////////////

    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_JALR = 6'b001001;
    localparam funct_t FN_ADDU = 6'b100001;

    // JAL always links here
    localparam reg_idx_t LINK_REG = 5'd31;

    // Occupancy of the retire register in execute
    typedef enum logic [1:0] {
        EX_IDLE,
        EX_BUSY,
        EX_HOLD
    } exec_state_t;

endpackage
